//--- include/lsu_defs.svh
// ------------------------------
// sizes shared by the LSU, its queues
// and the data memory; include where a
// width or depth is needed
// ------------------------------
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

`define LSU_XLEN       64   // integer register width
`define LSU_ADDR_W     32   // AXI4-Lite address width

// data memory in 64-bit words, 4 KiB
`define LSU_MEM_WORDS  512

`define LSU_FIFO_DEPTH 2    // entries per queue

`endif

//--- design/lsu_pkg.sv
// ------------------------------
// pipeline types for the memory stage
// op encoding and the ex/wb records
// ------------------------------
`include "lsu_defs.svh"

package lsu_pkg;

    // one value per supported op, stores last
    typedef enum logic [3:0] {
        OP_ALU,
        OP_LB,
        OP_LH,
        OP_LW,
        OP_LD,
        OP_LBU,
        OP_LHU,
        OP_LWU,
        OP_SB,
        OP_SH,
        OP_SW,
        OP_SD
    } lsu_op_e;

    // execute to memory
    typedef struct packed {
        logic [63:0]          pc;
        lsu_op_e              op;
        logic [4:0]           rd;
        logic [`LSU_XLEN-1:0] alu_res;  // address for loads and stores
        logic [`LSU_XLEN-1:0] st_data;  // rs2 value
    } ex_mem_t;

    // memory to writeback
    typedef struct packed {
        logic [63:0]          pc;
        logic [4:0]           rd;
        logic                 wen;
        logic [`LSU_XLEN-1:0] wdata;
        logic                 misaligned;
        logic                 fault;      // bus error on the access
    } mem_wb_t;

endpackage

//--- design/axil_pkg.sv
// ------------------------------
// memory request/response records and
// AXI4-Lite channel payloads
// ------------------------------
`include "lsu_defs.svh"

package axil_pkg;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // one queued access
    typedef struct packed {
        logic                   write;
        logic [`LSU_ADDR_W-1:0] addr;
        logic [`LSU_XLEN-1:0]   data;   // already placed in its byte lanes
        logic [7:0]             strb;
    } mem_req_t;

    typedef struct packed {
        logic [`LSU_XLEN-1:0] data;     // zero for writes
        logic [1:0]           resp;
    } mem_rsp_t;

    // channel payloads, valid/ready stay separate
    typedef struct packed {
        logic [`LSU_ADDR_W-1:0] addr;
        logic [2:0]             prot;
    } axil_aw_t;

    typedef struct packed {
        logic [`LSU_XLEN-1:0] data;
        logic [7:0]           strb;
    } axil_w_t;

    typedef struct packed {
        logic [1:0] resp;
    } axil_b_t;

    typedef struct packed {
        logic [`LSU_ADDR_W-1:0] addr;
        logic [2:0]             prot;
    } axil_ar_t;

    typedef struct packed {
        logic [`LSU_XLEN-1:0] data;
        logic [1:0]           resp;
    } axil_r_t;

endpackage

//--- design/lsu_fifo.sv
// ------------------------------
// small synchronous FIFO, payload type
// set per instance; flags come from flops
// ------------------------------
`timescale 1ns/10ps
`include "lsu_defs.svh"

module lsu_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = `LSU_FIFO_DEPTH
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    localparam int PW = (depth > 1) ? $clog2(depth) : 1;
    localparam int CW = $clog2(depth + 1);

    payload_t        mem [depth];
    logic [PW-1:0]   wr_ptr;
    logic [PW-1:0]   rd_ptr;
    logic [CW-1:0]   count;
    logic [CW-1:0]   count_nxt;
    logic            push;
    logic            pop;

    function automatic logic [PW-1:0] bump(input logic [PW-1:0] p);
        return (p == PW'(depth - 1)) ? '0 : p + 1'b1;  // wrap
    endfunction

    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;
    assign count_nxt = count + CW'(push) - CW'(pop);
    assign out_data  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_ready  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (push)
                wr_ptr <= bump(wr_ptr);
            if (pop)
                rd_ptr <= bump(rd_ptr);
            count     <= count_nxt;
            in_ready  <= (count_nxt != CW'(depth));  // full blocks the writer
            out_valid <= (count_nxt != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= in_data;
    end

endmodule

//--- design/mem_stage.sv
// ------------------------------
// memory stage of the pipeline
// holds one instruction, issues a load
// or store request and builds the wb record
// ------------------------------
`timescale 1ns/10ps
`include "lsu_defs.svh"

module mem_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               ex_valid,
    output logic               ex_ready,
    input  lsu_pkg::ex_mem_t   ex_rec,
    output logic               wb_valid,
    input  logic               wb_ready,
    output lsu_pkg::mem_wb_t   wb_rec,
    output logic               req_valid,
    input  logic               req_ready,
    output axil_pkg::mem_req_t req,
    input  logic               rsp_valid,
    output logic               rsp_ready,
    input  axil_pkg::mem_rsp_t rsp
);

    typedef enum logic [1:0] {S_IDLE, S_ISSUE, S_WAIT, S_WB} state_e;

    state_e               state;
    state_e               state_nxt;
    lsu_pkg::ex_mem_t     rec_q;       // stage register
    logic [`LSU_XLEN-1:0] rdata_q;
    logic [1:0]           resp_q;
    logic                 take;
    logic                 is_mem;
    logic                 is_store;
    logic                 mis;
    logic [`LSU_XLEN-1:0] lane;        // loaded word shifted down to byte 0

    // natural alignment per access size
    function automatic logic misaligned(input lsu_pkg::lsu_op_e op, input logic [2:0] a);
        case (op)
            lsu_pkg::OP_LH, lsu_pkg::OP_LHU, lsu_pkg::OP_SH: return a[0];
            lsu_pkg::OP_LW, lsu_pkg::OP_LWU, lsu_pkg::OP_SW: return a[1:0] != 2'b00;
            lsu_pkg::OP_LD, lsu_pkg::OP_SD:                  return a != 3'b000;
            default:                                         return 1'b0;
        endcase
    endfunction

    assign take      = ex_valid && ex_ready;
    // empty or draining, never in reset
    assign ex_ready  = !rst && ((state == S_IDLE) || (state == S_WB && wb_ready));
    assign wb_valid  = (state == S_WB);
    assign req_valid = (state == S_ISSUE);
    assign rsp_ready = (state == S_WAIT);

    always_comb begin
        state_nxt = state;
        case (state)
            S_ISSUE: if (req_ready) state_nxt = S_WAIT;
            S_WAIT:  if (rsp_valid) state_nxt = S_WB;
            S_WB:    if (wb_ready) state_nxt = S_IDLE;
            default: state_nxt = S_IDLE;
        endcase
        // a new record decides for itself
        // ALU and misaligned ops skip the queue
        if (take) begin
            if (ex_rec.op != lsu_pkg::OP_ALU && !misaligned(ex_rec.op, ex_rec.alu_res[2:0]))
                state_nxt = S_ISSUE;
            else
                state_nxt = S_WB;
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            state <= S_IDLE;
        else
            state <= state_nxt;
    end

    always_ff @(posedge clk) begin
        if (take)
            rec_q <= ex_rec;
        if (rsp_valid && rsp_ready) begin
            rdata_q <= rsp.data;
            resp_q  <= rsp.resp;
        end
    end

    assign is_mem   = (rec_q.op != lsu_pkg::OP_ALU);
    assign is_store = rec_q.op inside {lsu_pkg::OP_SB, lsu_pkg::OP_SH,
                                       lsu_pkg::OP_SW, lsu_pkg::OP_SD};
    assign mis      = misaligned(rec_q.op, rec_q.alu_res[2:0]);

    // store data moved to its lanes and the strobe to match
    always_comb begin
        req.write = is_store;
        req.addr  = rec_q.alu_res[`LSU_ADDR_W-1:0];
        req.data  = rec_q.st_data << {rec_q.alu_res[2:0], 3'b000};
        case (rec_q.op)
            lsu_pkg::OP_SB: req.strb = 8'h01 << rec_q.alu_res[2:0];
            lsu_pkg::OP_SH: req.strb = 8'h03 << rec_q.alu_res[2:0];
            lsu_pkg::OP_SW: req.strb = 8'h0f << rec_q.alu_res[2:0];
            lsu_pkg::OP_SD: req.strb = 8'hff;
            default:        req.strb = 8'h00;  // loads
        endcase
    end

    assign lane = rdata_q >> {rec_q.alu_res[2:0], 3'b000};

    always_comb begin
        wb_rec.pc         = rec_q.pc;
        wb_rec.rd         = rec_q.rd;
        wb_rec.misaligned = mis;
        wb_rec.fault      = is_mem && !mis && (resp_q != axil_pkg::RESP_OKAY);
        case (rec_q.op)
            lsu_pkg::OP_ALU: wb_rec.wdata = rec_q.alu_res;
            lsu_pkg::OP_LB:  wb_rec.wdata = {{56{lane[7]}}, lane[7:0]};
            lsu_pkg::OP_LH:  wb_rec.wdata = {{48{lane[15]}}, lane[15:0]};
            lsu_pkg::OP_LW:  wb_rec.wdata = {{32{lane[31]}}, lane[31:0]};
            lsu_pkg::OP_LD:  wb_rec.wdata = rdata_q;
            lsu_pkg::OP_LBU: wb_rec.wdata = {56'd0, lane[7:0]};
            lsu_pkg::OP_LHU: wb_rec.wdata = {48'd0, lane[15:0]};
            lsu_pkg::OP_LWU: wb_rec.wdata = {32'd0, lane[31:0]};
            default:         wb_rec.wdata = '0;
        endcase
        // only ALU ops and clean loads write the register file
        wb_rec.wen = !is_mem || (!is_store && !mis && !wb_rec.fault);
        if (!wb_rec.wen)
            wb_rec.wdata = '0;
    end

endmodule

//--- design/lsu_axil_master.sv
// ------------------------------
// AXI4-Lite master for the LSU
// one queued request at a time, result
// pushed to the response queue
// ------------------------------
`timescale 1ns/10ps

module lsu_axil_master (
    input  logic               clk,
    input  logic               rst,
    input  logic               req_valid,
    output logic               req_ready,
    input  axil_pkg::mem_req_t req,
    output logic               rsp_valid,
    input  logic               rsp_ready,
    output axil_pkg::mem_rsp_t rsp,
    output logic               awvalid,
    input  logic               awready,
    output axil_pkg::axil_aw_t aw,
    output logic               wvalid,
    input  logic               wready,
    output axil_pkg::axil_w_t  w,
    input  logic               bvalid,
    output logic               bready,
    input  axil_pkg::axil_b_t  b,
    output logic               arvalid,
    input  logic               arready,
    output axil_pkg::axil_ar_t ar,
    input  logic               rvalid,
    output logic               rready,
    input  axil_pkg::axil_r_t  r
);

    typedef enum logic [1:0] {M_IDLE, M_WR, M_RD, M_RSP} state_e;

    state_e             state;
    axil_pkg::mem_req_t req_q;
    logic               aw_pend;   // aw not yet accepted
    logic               w_pend;
    logic               ar_pend;

    assign req_ready = (state == M_IDLE);  // next pop waits for the response push
    assign rsp_valid = (state == M_RSP);
    assign awvalid   = aw_pend;
    assign wvalid    = w_pend;
    assign arvalid   = ar_pend;
    assign bready    = (state == M_WR) && !aw_pend && !w_pend;
    assign rready    = (state == M_RD) && !ar_pend;

    always_comb begin
        aw.addr = req_q.addr;
        aw.prot = 3'b000;       // unprivileged data
        w.data  = req_q.data;
        w.strb  = req_q.strb;
        ar.addr = req_q.addr;
        ar.prot = 3'b000;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= M_IDLE;
            aw_pend <= 1'b0;
            w_pend  <= 1'b0;
            ar_pend <= 1'b0;
        end else begin
            case (state)
                M_IDLE: if (req_valid) begin
                    state   <= req.write ? M_WR : M_RD;
                    aw_pend <= req.write;  // aw and w go out together
                    w_pend  <= req.write;
                    ar_pend <= !req.write;
                end
                M_WR: begin
                    if (awvalid && awready)
                        aw_pend <= 1'b0;
                    if (wvalid && wready)
                        w_pend <= 1'b0;
                    if (bvalid && bready)
                        state <= M_RSP;
                end
                M_RD: begin
                    if (arvalid && arready)
                        ar_pend <= 1'b0;
                    if (rvalid && rready)
                        state <= M_RSP;
                end
                M_RSP: if (rsp_ready) state <= M_IDLE;
                default: state <= M_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready)
            req_q <= req;
        if (bvalid && bready) begin
            rsp.data <= '0;        // nothing to return on a write
            rsp.resp <= b.resp;
        end
        if (rvalid && rready) begin
            rsp.data <= r.data;
            rsp.resp <= r.resp;
        end
    end

endmodule

//--- design/data_mem_axil.sv
// ------------------------------
// on-chip data RAM behind an AXI4-Lite
// slave; b and r answer one cycle after
// the address handshake
// ------------------------------
`timescale 1ns/10ps
`include "lsu_defs.svh"

module data_mem_axil (
    input  logic               clk,
    input  logic               rst,
    input  logic               awvalid,
    output logic               awready,
    input  axil_pkg::axil_aw_t aw,
    input  logic               wvalid,
    output logic               wready,
    input  axil_pkg::axil_w_t  w,
    output logic               bvalid,
    input  logic               bready,
    output axil_pkg::axil_b_t  b,
    input  logic               arvalid,
    output logic               arready,
    input  axil_pkg::axil_ar_t ar,
    output logic               rvalid,
    input  logic               rready,
    output axil_pkg::axil_r_t  r
);

    localparam int IW = $clog2(`LSU_MEM_WORDS);
    localparam logic [`LSU_ADDR_W-1:0] MEM_BYTES = `LSU_MEM_WORDS * 8;

    logic [`LSU_XLEN-1:0] ram [`LSU_MEM_WORDS];
    logic                 wr_go;
    logic                 rd_go;
    logic                 wr_ok;     // address inside the RAM
    logic                 rd_ok;
    logic [IW-1:0]        wr_idx;
    logic [IW-1:0]        rd_idx;

    initial begin
        for (int i = 0; i < `LSU_MEM_WORDS; i++)
            ram[i] = '0;
    end

    // aw and w taken in the same cycle, not while b is pending
    assign awready = awvalid && wvalid && !bvalid;
    assign wready  = awready;
    assign arready = arvalid && !rvalid;
    assign wr_go   = awvalid && awready;
    assign rd_go   = arvalid && arready;
    assign wr_ok   = aw.addr < MEM_BYTES;
    assign rd_ok   = ar.addr < MEM_BYTES;
    assign wr_idx  = aw.addr[IW+2:3];  // 64-bit word index
    assign rd_idx  = ar.addr[IW+2:3];

    always_ff @(posedge clk) begin
        if (wr_go && wr_ok) begin
            for (int i = 0; i < 8; i++)
                if (w.strb[i])
                    ram[wr_idx][8*i +: 8] <= w.data[8*i +: 8];
        end
        if (wr_go)
            b.resp <= wr_ok ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
        if (rd_go) begin
            r.data <= rd_ok ? ram[rd_idx] : '0;
            r.resp <= rd_ok ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wr_go)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;
            if (rd_go)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

endmodule

//--- design/lsu_top.sv
// ------------------------------
// LSU top level: memory stage, request
// and response queues, AXI4-Lite master
// and the data memory
// ------------------------------
`timescale 1ns/10ps
`include "lsu_defs.svh"

module lsu_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             ex_valid,
    output logic             ex_ready,
    input  lsu_pkg::ex_mem_t ex_rec,
    output logic             wb_valid,
    input  logic             wb_ready,
    output lsu_pkg::mem_wb_t wb_rec
);

    // stage side of the queues
    logic               s_req_valid;
    logic               s_req_ready;
    axil_pkg::mem_req_t s_req;
    logic               s_rsp_valid;
    logic               s_rsp_ready;
    axil_pkg::mem_rsp_t s_rsp;
    // master side
    logic               m_req_valid;
    logic               m_req_ready;
    axil_pkg::mem_req_t m_req;
    logic               m_rsp_valid;
    logic               m_rsp_ready;
    axil_pkg::mem_rsp_t m_rsp;
    // AXI4-Lite
    logic               awvalid;
    logic               awready;
    axil_pkg::axil_aw_t aw;
    logic               wvalid;
    logic               wready;
    axil_pkg::axil_w_t  w;
    logic               bvalid;
    logic               bready;
    axil_pkg::axil_b_t  b;
    logic               arvalid;
    logic               arready;
    axil_pkg::axil_ar_t ar;
    logic               rvalid;
    logic               rready;
    axil_pkg::axil_r_t  r;

    mem_stage u_stage (
        .clk(clk), .rst(rst),
        .ex_valid(ex_valid), .ex_ready(ex_ready), .ex_rec(ex_rec),
        .wb_valid(wb_valid), .wb_ready(wb_ready), .wb_rec(wb_rec),
        .req_valid(s_req_valid), .req_ready(s_req_ready), .req(s_req),
        .rsp_valid(s_rsp_valid), .rsp_ready(s_rsp_ready), .rsp(s_rsp)
    );

    lsu_fifo #(.payload_t(axil_pkg::mem_req_t), .depth(`LSU_FIFO_DEPTH)) u_req_q (
        .clk(clk), .rst(rst),
        .in_valid(s_req_valid), .in_ready(s_req_ready), .in_data(s_req),
        .out_valid(m_req_valid), .out_ready(m_req_ready), .out_data(m_req)
    );

    lsu_fifo #(.payload_t(axil_pkg::mem_rsp_t), .depth(`LSU_FIFO_DEPTH)) u_rsp_q (
        .clk(clk), .rst(rst),
        .in_valid(m_rsp_valid), .in_ready(m_rsp_ready), .in_data(m_rsp),
        .out_valid(s_rsp_valid), .out_ready(s_rsp_ready), .out_data(s_rsp)
    );

    lsu_axil_master u_master (
        .clk(clk), .rst(rst),
        .req_valid(m_req_valid), .req_ready(m_req_ready), .req(m_req),
        .rsp_valid(m_rsp_valid), .rsp_ready(m_rsp_ready), .rsp(m_rsp),
        .awvalid(awvalid), .awready(awready), .aw(aw),
        .wvalid(wvalid), .wready(wready), .w(w),
        .bvalid(bvalid), .bready(bready), .b(b),
        .arvalid(arvalid), .arready(arready), .ar(ar),
        .rvalid(rvalid), .rready(rready), .r(r)
    );

    data_mem_axil u_mem (
        .clk(clk), .rst(rst),
        .awvalid(awvalid), .awready(awready), .aw(aw),
        .wvalid(wvalid), .wready(wready), .w(w),
        .bvalid(bvalid), .bready(bready), .b(b),
        .arvalid(arvalid), .arready(arready), .ar(ar),
        .rvalid(rvalid), .rready(rready), .r(r)
    );

endmodule

//--- testbench/lsu_sva.sv
// ------------------------------
// AXI4-Lite handshake checks, bound
// into every lsu_axil_master
// ------------------------------
`timescale 1ns/10ps

module lsu_sva (
    input logic               clk,
    input logic               rst,
    input logic               awvalid,
    input logic               awready,
    input axil_pkg::axil_aw_t aw,
    input logic               wvalid,
    input logic               wready,
    input axil_pkg::axil_w_t  w,
    input logic               bvalid,
    input logic               arvalid,
    input logic               arready,
    input axil_pkg::axil_ar_t ar,
    input logic               rvalid
);

    logic rst_q;  // reset also held on the previous edge

    always_ff @(posedge clk)
        rst_q <= rst;

    // valid and payload hold until the slave takes them
    aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(aw))
        else $error("awvalid dropped or aw changed before the handshake");

    w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(w))
        else $error("wvalid dropped or w changed before the handshake");

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(ar))
        else $error("arvalid dropped or ar changed before the handshake");

    quiet_in_reset: assert property (@(posedge clk)
        rst && rst_q |-> !(awvalid || wvalid || arvalid || bvalid || rvalid))
        else $error("AXI valid high during reset");

endmodule

bind lsu_axil_master lsu_sva u_sva (
    .clk(clk), .rst(rst),
    .awvalid(awvalid), .awready(awready), .aw(aw),
    .wvalid(wvalid), .wready(wready), .w(w),
    .bvalid(bvalid),
    .arvalid(arvalid), .arready(arready), .ar(ar),
    .rvalid(rvalid)
);

//--- testbench/lsu_tb.sv
// ------------------------------
// LSU testbench that replays the pattern
// file on the ex port and checks wb records
// in order while wb_ready toggles at random
// ------------------------------
`timescale 1ns/10ps
`include "lsu_defs.svh"

module lsu_tb;

    localparam int MAX_TESTS    = 64;
    localparam int RESET_CYCLES = 10;

    logic             clk;
    logic             rst;
    logic             ex_valid;
    logic             ex_ready;
    lsu_pkg::ex_mem_t ex_rec;
    logic             wb_valid;
    logic             wb_ready;
    lsu_pkg::mem_wb_t wb_rec;

    // pattern table with one entry per test
    logic [8*24-1:0]      t_name  [MAX_TESTS];
    logic [3:0]           t_op    [MAX_TESTS];
    logic [`LSU_XLEN-1:0] t_addr  [MAX_TESTS];
    logic [`LSU_XLEN-1:0] t_sdata [MAX_TESTS];
    logic [4:0]           t_rd    [MAX_TESTS];
    logic [`LSU_XLEN-1:0] t_wdata [MAX_TESTS];
    logic                 t_wen   [MAX_TESTS];
    logic                 t_mis   [MAX_TESTS];
    logic                 t_fault [MAX_TESTS];

    int     n_tests;
    int     n_seen;    // wb records received
    int     n_pass;
    int     n_fail;
    int     errors;    // failures outside the per-test compare
    integer seed;
    logic   loaded;

    lsu_top u_dut (
        .clk(clk), .rst(rst),
        .ex_valid(ex_valid), .ex_ready(ex_ready), .ex_rec(ex_rec),
        .wb_valid(wb_valid), .wb_ready(wb_ready), .wb_rec(wb_rec)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns
    end

    function automatic int op_code(input logic [8*8-1:0] s);
        case (s)
            "ALU":   return lsu_pkg::OP_ALU;
            "LB":    return lsu_pkg::OP_LB;
            "LH":    return lsu_pkg::OP_LH;
            "LW":    return lsu_pkg::OP_LW;
            "LD":    return lsu_pkg::OP_LD;
            "LBU":   return lsu_pkg::OP_LBU;
            "LHU":   return lsu_pkg::OP_LHU;
            "LWU":   return lsu_pkg::OP_LWU;
            "SB":    return lsu_pkg::OP_SB;
            "SH":    return lsu_pkg::OP_SH;
            "SW":    return lsu_pkg::OP_SW;
            "SD":    return lsu_pkg::OP_SD;
            default: return -1;
        endcase
    endfunction

    // fills the table and sets n to -1 when the file is missing
    task automatic load_patterns(output int n);
        int              fd;
        int              cnt;
        int              code;
        int              rdv;
        string           line;
        logic [8*24-1:0] nm;
        logic [8*8-1:0]  op_s;
        logic [63:0]     a;
        logic [63:0]     d;
        logic [63:0]     wd;
        logic            we;
        logic            mi;
        logic            fa;
        n  = 0;
        fd = $fopen("testbench/lsu_patterns.txt", "r");
        if (fd == 0) begin
            n = -1;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#")
                continue;   // blank or column notes
            cnt  = $sscanf(line, "%s %s %h %h %d %h %b %b %b",
                           nm, op_s, a, d, rdv, wd, we, mi, fa);
            code = op_code(op_s);
            if (cnt != 9 || code < 0 || n >= MAX_TESTS) begin
                $display("error: pattern line not understood: %s", line);
                errors++;
            end else begin
                t_name[n]  = nm;
                t_op[n]    = code[3:0];
                t_addr[n]  = a;
                t_sdata[n] = d;
                t_rd[n]    = rdv[4:0];
                t_wdata[n] = wd;
                t_wen[n]   = we;
                t_mis[n]   = mi;
                t_fault[n] = fa;
                n++;
            end
        end
        $fclose(fd);
    endtask

    // one record per handshake back to back
    task automatic drive_all();
        lsu_pkg::ex_mem_t rec;
        int               i;
        for (i = 0; i < n_tests; i++) begin
            rec.pc      = 64'h1000 + 64'(i) * 4;  // pc doubles as sequence tag
            rec.op      = lsu_pkg::lsu_op_e'(t_op[i]);
            rec.rd      = t_rd[i];
            rec.alu_res = t_addr[i];
            rec.st_data = t_sdata[i];
            ex_rec   <= rec;
            ex_valid <= 1'b1;
            @(posedge clk);
            while (!ex_ready)
                @(posedge clk);
        end
        ex_valid <= 1'b0;
    endtask

    task automatic check_record();
        int          i;
        logic [63:0] exp_pc;
        i      = n_seen;
        exp_pc = 64'h1000 + 64'(i) * 4;
        if (i >= n_tests) begin
            $display("error: writeback record after the last test, pc %h", wb_rec.pc);
            errors++;
        end else begin
            if (wb_rec.pc !== exp_pc || wb_rec.rd !== t_rd[i] || wb_rec.wen !== t_wen[i]
                    || wb_rec.wdata !== t_wdata[i] || wb_rec.misaligned !== t_mis[i]
                    || wb_rec.fault !== t_fault[i]) begin
                $write("mismatch %0s expected pc=%h rd=%0d wen=%b wdata=%h mis=%b fault=%b",
                       t_name[i], exp_pc, t_rd[i], t_wen[i], t_wdata[i], t_mis[i],
                       t_fault[i]);
                $display(" actual pc=%h rd=%0d wen=%b wdata=%h mis=%b fault=%b",
                         wb_rec.pc, wb_rec.rd, wb_rec.wen, wb_rec.wdata,
                         wb_rec.misaligned, wb_rec.fault);
                n_fail++;
            end else begin
                $display("pass %0s", t_name[i]);
                n_pass++;
            end
        end
        n_seen++;
    endtask

    // wb side samples the settled pre-edge values at each edge
    initial begin
        forever begin
            @(posedge clk);
            if (!rst && wb_valid && wb_ready)
                check_record();
            wb_ready <= ($random(seed) & 3) != 0;  // high about 3 cycles in 4
        end
    end

    initial begin
        rst      = 1'b1;
        ex_valid = 1'b0;
        ex_rec   = '0;
        wb_ready = 1'b0;
        seed     = 54;
        n_seen   = 0;
        n_pass   = 0;
        n_fail   = 0;
        errors   = 0;
        loaded   = 1'b0;
        load_patterns(n_tests);
        if (n_tests <= 0) begin
            $display("error: no usable patterns in testbench/lsu_patterns.txt");
            $display("Simulation FAILED");
            $finish;
        end else begin
            loaded = 1'b1;
            repeat (RESET_CYCLES) begin
                @(posedge clk);
                if (ex_ready === 1'b1 || wb_valid === 1'b1) begin
                    $display("error: ex_ready or wb_valid high during reset");
                    errors++;
                end
            end
            rst <= 1'b0;
            drive_all();
            wait (n_seen >= n_tests);
            repeat (5) @(posedge clk);  // room for a stray extra record
            $display("tests %0d, passed %0d, failed %0d, other errors %0d",
                     n_tests, n_pass, n_fail, errors);
            if (n_fail == 0 && errors == 0 && n_seen == n_tests)
                $display("Simulation PASSED");
            else
                $display("Simulation FAILED");
            $finish;
        end
    end

    // watchdog allows 40 cycles per test plus reset
    initial begin
        wait (loaded);
        repeat (n_tests * 40 + RESET_CYCLES) @(posedge clk);
        $display("error: timeout with %0d of %0d records written back", n_seen, n_tests);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- all.f
+incdir+include
design/lsu_pkg.sv
design/axil_pkg.sv
design/lsu_fifo.sv
design/mem_stage.sv
design/lsu_axil_master.sv
design/data_mem_axil.sv
design/lsu_top.sv
testbench/lsu_sva.sv
testbench/lsu_tb.sv

//--- testbench/lsu_patterns.txt
# columns: name op addr store_data rd exp_wdata exp_wen exp_misaligned exp_fault
# addr, store_data and exp_wdata in hex, rd in decimal, flags 0 or 1
alu_pass   ALU 123456789abcdef0 0                1  123456789abcdef0 1 0 0
alu_neg    ALU ffffffffffffff00 0                2  ffffffffffffff00 1 0 0
sd_100     SD  100              8877665544332211 0  0                0 0 0
ld_100     LD  100              0                3  8877665544332211 1 0 0
lb_107     LB  107              0                4  ffffffffffffff88 1 0 0
lbu_107    LBU 107              0                5  88               1 0 0
lh_106     LH  106              0                6  ffffffffffff8877 1 0 0
lhu_106    LHU 106              0                7  8877             1 0 0
lw_104     LW  104              0                8  ffffffff88776655 1 0 0
lwu_104    LWU 104              0                9  88776655         1 0 0
lw_100     LW  100              0                10 44332211         1 0 0
sb_203     SB  203              aaaaaaaaaaaaaa5a 0  0                0 0 0
ld_200     LD  200              0                11 5a000000         1 0 0
sh_20a     SH  20a              1234567890abf00d 0  0                0 0 0
ld_208     LD  208              0                12 f00d0000         1 0 0
lh_20a     LH  20a              0                13 fffffffffffff00d 1 0 0
sw_214     SW  214              deadbeefcafe0123 0  0                0 0 0
ld_210     LD  210              0                14 cafe012300000000 1 0 0
lw_214     LW  214              0                15 ffffffffcafe0123 1 0 0
lbu_212    LBU 212              0                16 0                1 0 0
lh_mis     LH  101              0                17 0                0 1 0
sw_mis     SW  102              ffffffffffffffff 0  0                0 1 0
ld_mis     LD  104              0                18 0                0 1 0
ld_after   LD  100              0                19 8877665544332211 1 0 0
sd_oor     SD  1000             1111             0  0                0 0 1
ld_oor     LD  1000             0                20 0                0 0 1
lb_oor     LB  fffffff0         0                21 0                0 0 1
sd_last    SD  ff8              0123456789abcdef 0  0                0 0 0
ld_last    LD  ff8              0                22 0123456789abcdef 1 0 0
ld_0       LD  0                0                23 0                1 0 0
alu_end    ALU 42               0                24 42               1 0 0
